// ==== trace_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared definitions for the execution trace monitor
// bus phase codes, transfer size and the retirement record
// imported by every RTL module and by the testbench
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package trace_pkg;

    // rv32 only
    localparam int unsigned XLEN = 32;

    // bus phase codes, as driven by the core FSM
    typedef enum logic [2:0] {
        IF  = 3'b000,  // instruction fetch
        MLD = 3'b001,  // memory load
        MST = 3'b010,  // memory store
        EXE = 3'b011,  // execute, branch condition only
        WB  = 3'b100,  // register write-back
        RS1 = 3'b101,  // register read, source 1
        RS2 = 3'b110   // register read, source 2
    } pha_t;

    // logarithmic transfer size
    typedef enum logic [1:0] {
        SIZ_B = 2'd0,  // byte
        SIZ_H = 2'd1,  // half
        SIZ_W = 2'd2   // word
    } siz_t;

    // one retired instruction
    typedef struct packed {
        logic [XLEN-1:0] ifu_adr;  // pc
        logic [XLEN-1:0] ifu_ins;  // instruction word
        logic            ifu_ill;  // not a 32-bit encoding
        logic            wbu_ena;  // write-back valid
        logic [     4:0] wbu_idx;  // destination register
        logic [XLEN-1:0] wbu_dat;  // write-back data
        logic            lsu_ena;  // load/store valid
        logic            lsu_wen;  // store
        logic            lsu_ren;  // load
        logic [XLEN-1:0] lsu_adr;
        siz_t            lsu_siz;
        logic [XLEN-1:0] lsu_wdt;  // store data
        logic [XLEN-1:0] lsu_rdt;  // load data
    } trace_rec_t;

endpackage

`default_nettype wire

// ==== trace_assembler.sv ====
////////////////////////////////////////////////////////////////////////////
// retirement record assembler
// pairs each bus request with its response one cycle later and collects
// fetch, write-back and load/store transfers into one record; the next
// fetch closes the record and pushes it for one cycle
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module trace_assembler
    import trace_pkg::*;
(
    input  logic            tcb,
    input  logic            rst,
    // monitored bus
    input  logic            trn,
    input  pha_t            pha,
    input  logic [XLEN-1:0] req_adr,
    input  logic [XLEN-1:0] req_wdt,
    input  siz_t            req_siz,
    input  logic [XLEN-1:0] rsp_rdt,
    // finished record
    output logic            rec_push,
    output trace_rec_t      rec
);

////////////////////////////////////////////////////////////////////////////
// request stage
////////////////////////////////////////////////////////////////////////////

    logic            dly_trn;  // transfer in previous cycle
    pha_t            dly_pha;
    logic [XLEN-1:0] dly_adr;
    logic [XLEN-1:0] dly_wdt;
    siz_t            dly_siz;

    always_ff @(posedge tcb) begin
        if (rst) begin
            dly_trn <= 1'b0;
        end else begin
            dly_trn <= trn;
        end
    end

    // request payload, qualified by dly_trn
    always_ff @(posedge tcb) begin
        dly_pha <= pha;
        dly_adr <= req_adr;
        dly_wdt <= req_wdt;
        dly_siz <= req_siz;
    end

////////////////////////////////////////////////////////////////////////////
// record control
////////////////////////////////////////////////////////////////////////////

    logic       rec_open;  // a fetch has been seen since reset
    logic       dly_ifu;   // fetch completes this cycle
    trace_rec_t cur;       // record being built

    assign dly_ifu = dly_trn && (dly_pha == IF);

    always_ff @(posedge tcb) begin
        if (rst) begin
            rec_open <= 1'b0;
            rec_push <= 1'b0;
        end else begin
            rec_push <= dly_ifu && rec_open;  // first fetch pushes nothing
            if (dly_ifu) begin
                rec_open <= 1'b1;
            end
        end
    end

////////////////////////////////////////////////////////////////////////////
// record payload
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge tcb) begin
        if (dly_trn) begin
            case (dly_pha)
                IF: begin
                    // hand over the finished record, start a fresh one
                    rec <= cur;
                    cur <= '0;
                    cur.ifu_adr <= dly_adr;
                    cur.ifu_ins <= rsp_rdt;
                    cur.ifu_ill <= (rsp_rdt[1:0] != 2'b11);  // 16-bit encodings
                end
                WB: begin
                    cur.wbu_ena <= 1'b1;
                    cur.wbu_idx <= dly_adr[6:2];  // register index on address
                    cur.wbu_dat <= dly_wdt;
                end
                MLD: begin
                    cur.lsu_ena <= 1'b1;
                    cur.lsu_ren <= 1'b1;
                    cur.lsu_adr <= dly_adr;
                    cur.lsu_siz <= dly_siz;
                    cur.lsu_rdt <= rsp_rdt;  // response of the load
                end
                MST: begin
                    cur.lsu_ena <= 1'b1;
                    cur.lsu_wen <= 1'b1;
                    cur.lsu_adr <= dly_adr;
                    cur.lsu_siz <= dly_siz;
                    cur.lsu_wdt <= dly_wdt;
                end
                default: begin
                    // RS1, RS2, EXE leave the record alone
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== trace_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// record queue, first word fall through
// head is valid while avail is high, pop retires it at the clock edge;
// a push into a full queue is dropped and sets the sticky ovf flag
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module trace_fifo
    import trace_pkg::*;
#(
    parameter int unsigned DEPTH = 4  // power of two
)(
    input  logic       tcb,
    input  logic       rst,
    // write side
    input  logic       push,
    input  trace_rec_t din,
    // read side
    input  logic       pop,
    output trace_rec_t head,
    output logic       avail,
    // status
    output logic       ovf
);

    localparam int unsigned AW = $clog2(DEPTH);

    trace_rec_t    mem [DEPTH];
    logic [AW:0]   wr_ptr;  // extra bit tells full from empty
    logic [AW:0]   rd_ptr;
    logic          full;
    logic          empty;
    logic          wr_ena;
    logic          rd_ena;

    assign empty  = (wr_ptr == rd_ptr);
    assign full   = (wr_ptr[AW] != rd_ptr[AW])
                 && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_ena = push && !full;
    assign rd_ena = pop && !empty;  // pop on empty is ignored

    // pointers and overflow
    always_ff @(posedge tcb) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            ovf    <= 1'b0;
        end else begin
            if (wr_ena) wr_ptr <= wr_ptr + 1'b1;
            if (rd_ena) rd_ptr <= rd_ptr + 1'b1;
            if (push && full) ovf <= 1'b1;  // sticky until reset
        end
    end

    // storage
    always_ff @(posedge tcb) begin
        if (wr_ena) begin
            mem[wr_ptr[AW-1:0]] <= din;
        end
    end

    assign head  = mem[rd_ptr[AW-1:0]];
    assign avail = !empty;

endmodule

`default_nettype wire

// ==== trace_stats.sv ====
////////////////////////////////////////////////////////////////////////////
// retirement statistics
// counts pushed records and their loads, stores and write-backs;
// counters wrap, clr zeroes all of them and wins over a push
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module trace_stats
    import trace_pkg::*;
#(
    parameter int unsigned CNT_W = 16
)(
    input  logic             tcb,
    input  logic             rst,
    input  logic             clr,
    // observed record stream
    input  logic             push,
    input  trace_rec_t       rec,
    // counters
    output logic [CNT_W-1:0] cnt_ins,
    output logic [CNT_W-1:0] cnt_ld,
    output logic [CNT_W-1:0] cnt_st,
    output logic [CNT_W-1:0] cnt_wb
);

    always_ff @(posedge tcb) begin
        if (rst || clr) begin
            cnt_ins <= '0;
            cnt_ld  <= '0;
            cnt_st  <= '0;
            cnt_wb  <= '0;
        end else if (push) begin
            // dropped records count as well
            cnt_ins <= cnt_ins + 1'b1;
            cnt_ld  <= cnt_ld + CNT_W'(rec.lsu_ren);
            cnt_st  <= cnt_st + CNT_W'(rec.lsu_wen);
            cnt_wb  <= cnt_wb + CNT_W'(rec.wbu_ena);
        end
    end

endmodule

`default_nettype wire

// ==== trace_monitor.sv ====
////////////////////////////////////////////////////////////////////////////
// passive execution trace monitor, top level
// watches the core system bus, never stalls it; records come out of
// the queue with rec_pop, statistics are cleared with clr
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module trace_monitor
    import trace_pkg::*;
#(
    parameter int unsigned DEPTH = 4,   // queue depth, power of two
    parameter int unsigned CNT_W = 16   // counter width
)(
    input  logic             tcb,
    input  logic             rst,
    // monitored bus
    input  logic             trn,
    input  pha_t             pha,
    input  logic [XLEN-1:0]  req_adr,
    input  logic [XLEN-1:0]  req_wdt,
    input  siz_t             req_siz,
    input  logic [XLEN-1:0]  rsp_rdt,
    // record queue
    input  logic             rec_pop,
    output trace_rec_t       rec_head,
    output logic             rec_avail,
    output logic             ovf,
    // statistics
    input  logic             clr,
    output logic [CNT_W-1:0] cnt_ins,
    output logic [CNT_W-1:0] cnt_ld,
    output logic [CNT_W-1:0] cnt_st,
    output logic [CNT_W-1:0] cnt_wb
);

    logic       rec_push;  // one cycle per finished record
    trace_rec_t rec;

    trace_assembler trace_assembler_i (
        .tcb      (tcb),
        .rst      (rst),
        .trn      (trn),
        .pha      (pha),
        .req_adr  (req_adr),
        .req_wdt  (req_wdt),
        .req_siz  (req_siz),
        .rsp_rdt  (rsp_rdt),
        .rec_push (rec_push),
        .rec      (rec)
    );

    trace_fifo #(
        .DEPTH (DEPTH)
    ) trace_fifo_i (
        .tcb   (tcb),
        .rst   (rst),
        .push  (rec_push),
        .din   (rec),
        .pop   (rec_pop),
        .head  (rec_head),
        .avail (rec_avail),
        .ovf   (ovf)
    );

    // sees every push, also those the queue drops
    trace_stats #(
        .CNT_W (CNT_W)
    ) trace_stats_i (
        .tcb     (tcb),
        .rst     (rst),
        .clr     (clr),
        .push    (rec_push),
        .rec     (rec),
        .cnt_ins (cnt_ins),
        .cnt_ld  (cnt_ld),
        .cnt_st  (cnt_st),
        .cnt_wb  (cnt_wb)
    );

endmodule

`default_nettype wire

// ==== trace_monitor_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// self-checking testbench for the trace monitor
// replays bus transfers from the testdata file, drains and compares the
// records, then checks overflow, the counters and their clear strobe
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module trace_monitor_tb
    import trace_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned DEPTH = 4;
    localparam int unsigned CNT_W = 16;
    localparam int          TMO   = 200;  // cycles per wait

    typedef struct packed {
        pha_t            pha;
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] wdt;
        siz_t            siz;
        logic [XLEN-1:0] rdt;  // response driven one cycle later
    } xfer_t;

    logic tcb = 1'b0;
    logic rst;
    logic trn;
    pha_t pha;
    logic [XLEN-1:0] req_adr;
    logic [XLEN-1:0] req_wdt;
    siz_t req_siz;
    logic [XLEN-1:0] rsp_rdt;
    logic rec_pop;
    logic clr;
    trace_rec_t rec_head;
    logic rec_avail;
    logic ovf;
    logic [CNT_W-1:0] cnt_ins, cnt_ld, cnt_st, cnt_wb;

    xfer_t      a_xfer[$], b_xfer[$], drive_q[$];
    trace_rec_t a_rec[$], b_rec[$], expect_q[$];
    logic [CNT_W-1:0] exp_cnt[4];

    trace_monitor #(.DEPTH(DEPTH), .CNT_W(CNT_W)) trace_monitor_i (
        .tcb(tcb), .rst(rst), .trn(trn), .pha(pha), .req_adr(req_adr),
        .req_wdt(req_wdt), .req_siz(req_siz), .rsp_rdt(rsp_rdt),
        .rec_pop(rec_pop), .rec_head(rec_head), .rec_avail(rec_avail),
        .ovf(ovf), .clr(clr), .cnt_ins(cnt_ins), .cnt_ld(cnt_ld),
        .cnt_st(cnt_st), .cnt_wb(cnt_wb)
    );

    always #4 tcb = ~tcb;  // 8 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_rec(input string name, input trace_rec_t exp, input trace_rec_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_cnt(input string name, input logic [CNT_W-1:0] exp,
                             input logic [CNT_W-1:0] act);
        if (exp !== act) begin
            $display("error %s expected %0d actual %0d", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error %s expected %b actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // T/O transfers, R/Q records, C counters
    task automatic load_testdata();
        int fd;
        string line;
        logic [XLEN-1:0] v[13];
        xfer_t x;
        fd = $fopen("trace_monitor_testdata.txt", "r");
        if (fd == 0) abort_run("cannot open trace_monitor_testdata.txt");
        while ($fgets(line, fd)) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            void'($sscanf(line.substr(1, line.len() - 1),
                "%h %h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3],
                v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11], v[12]));
            x = {pha_t'(v[0][2:0]), v[1], v[2], siz_t'(v[3][1:0]), v[4]};
            case (line.getc(0))
                "T": a_xfer.push_back(x);
                "O": b_xfer.push_back(x);
                "R": a_rec.push_back({v[0], v[1], v[2][0], v[3][0], v[4][4:0], v[5],
                        v[6][0], v[7][0], v[8][0], v[9], siz_t'(v[10][1:0]), v[11], v[12]});
                "Q": b_rec.push_back({v[0], v[1], v[2][0], v[3][0], v[4][4:0], v[5],
                        v[6][0], v[7][0], v[8][0], v[9], siz_t'(v[10][1:0]), v[11], v[12]});
                "C": for (int i = 0; i < 4; i++) exp_cnt[i] = v[i][CNT_W-1:0];
                default: abort_run("unknown line kind in testdata");
            endcase
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        @(posedge tcb);
        rst <= 1'b1;
        repeat (3) @(posedge tcb);
        rst <= 1'b0;
        @(negedge tcb);
        check_flag("reset rec_avail", 1'b0, rec_avail);
        check_flag("reset ovf", 1'b0, ovf);
        check_cnt("reset cnt_ins", '0, cnt_ins);
        check_cnt("reset cnt_ld", '0, cnt_ld);
        check_cnt("reset cnt_st", '0, cnt_st);
        check_cnt("reset cnt_wb", '0, cnt_wb);
    endtask

    // one transfer per strobe, read data in the next cycle, random idle gaps
    task automatic drive_all();
        logic [XLEN-1:0] pend;
        int gap;
        pend = '0;
        foreach (drive_q[i]) begin
            @(posedge tcb);
            trn     <= 1'b1;
            pha     <= drive_q[i].pha;
            req_adr <= drive_q[i].adr;
            req_wdt <= drive_q[i].wdt;
            req_siz <= drive_q[i].siz;
            rsp_rdt <= pend;  // response of previous transfer
            pend = drive_q[i].rdt;
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge tcb);
                trn     <= 1'b0;
                rsp_rdt <= pend;
            end
        end
        @(posedge tcb);
        trn     <= 1'b0;
        rsp_rdt <= pend;
    endtask

    // pops each expected record after a random delay
    task automatic drain_all(input string name);
        int t;
        foreach (expect_q[k]) begin
            t = 0;
            @(negedge tcb);
            while (!rec_avail) begin
                if (t >= TMO) abort_run("timeout waiting for a record in the queue");
                t++;
                @(negedge tcb);
            end
            check_rec($sformatf("%s record %0d", name, k), expect_q[k], rec_head);
            @(posedge tcb);
            rec_pop <= 1'b1;
            @(posedge tcb);
            rec_pop <= 1'b0;  // head retired at this edge
            repeat ($urandom % 3) @(posedge tcb);
        end
    endtask

    initial begin
        int t;
        void'($urandom(31623));
        rst     = 1'b1;
        trn     = 1'b0;
        pha     = IF;
        req_adr = '0;
        req_wdt = '0;
        req_siz = SIZ_W;
        rsp_rdt = '0;
        rec_pop = 1'b0;
        clr     = 1'b0;
        load_testdata();

        ////////////////////////////////////////////////////////////////////////
        // program with concurrent draining
        ////////////////////////////////////////////////////////////////////////
        apply_reset();
        drive_q = a_xfer;
        expect_q = a_rec;
        fork
            drive_all();
            drain_all("program");
        join
        repeat (4) @(posedge tcb);
        @(negedge tcb);
        check_flag("last instruction still open", 1'b0, rec_avail);
        check_flag("program ovf", 1'b0, ovf);

        ////////////////////////////////////////////////////////////////////////
        // overflow with six instructions and no pops
        ////////////////////////////////////////////////////////////////////////
        apply_reset();
        drive_q = b_xfer;
        drive_all();
        t = 0;
        @(negedge tcb);
        while (cnt_ins !== exp_cnt[0]) begin
            if (t >= TMO) abort_run("timeout waiting for the instruction counter");
            t++;
            @(negedge tcb);
        end
        check_flag("overflow ovf", 1'b1, ovf);
        check_cnt("overflow cnt_ins", exp_cnt[0], cnt_ins);
        check_cnt("overflow cnt_ld", exp_cnt[1], cnt_ld);
        check_cnt("overflow cnt_st", exp_cnt[2], cnt_st);
        check_cnt("overflow cnt_wb", exp_cnt[3], cnt_wb);
        expect_q = b_rec;
        drain_all("overflow");
        @(negedge tcb);
        check_flag("queue empty after drain", 1'b0, rec_avail);

        @(posedge tcb);
        clr <= 1'b1;
        @(posedge tcb);
        clr <= 1'b0;
        @(negedge tcb);
        check_cnt("clear cnt_ins", '0, cnt_ins);
        check_cnt("clear cnt_ld", '0, cnt_ld);
        check_cnt("clear cnt_st", '0, cnt_st);
        check_cnt("clear cnt_wb", '0, cnt_wb);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== trace_monitor_testdata.txt ====
# T/O: phase adr wdt siz rdt (phase 0 IF 1 MLD 2 MST 3 EXE 4 WB 5 RS1 6 RS2)
# R/Q: adr ins ill wb_ena wb_idx wb_dat ls_ena ls_wen ls_ren ls_adr ls_siz ls_wdt ls_rdt
T 0 00000000 00000000 2 00500093
T 5 00000000 00000000 2 00000000
T 3 00000000 00000000 2 00000000
T 4 00000004 00000005 2 00000000
T 0 00000004 00000000 2 10002103
T 1 00000100 00000000 2 deadbeef
T 4 00000008 deadbeef 2 00000000
T 0 00000008 00000000 2 10100223
T 6 00000004 00000000 2 00000005
T 2 00000104 00000005 0 00000000
T 0 0000000c 00000000 2 00208463
T 5 00000004 00000000 2 00000005
T 6 00000008 00000000 2 deadbeef
T 3 00000000 00000000 2 00000000
T 0 00000010 00000000 2 00004501
T 0 00000012 00000000 2 00000013
R 00000000 00500093 0 1 01 00000005 0 0 0 00000000 0 00000000 00000000
R 00000004 10002103 0 1 02 deadbeef 1 0 1 00000100 2 00000000 deadbeef
R 00000008 10100223 0 0 00 00000000 1 1 0 00000104 0 00000005 00000000
R 0000000c 00208463 0 0 00 00000000 0 0 0 00000000 0 00000000 00000000
R 00000010 00004501 1 0 00 00000000 0 0 0 00000000 0 00000000 00000000
O 0 00000200 00000000 2 00100193
O 4 0000000c 00000001 2 00000000
O 0 00000204 00000000 2 04302023
O 2 00000040 00000001 2 00000000
O 0 00000208 00000000 2 04001203
O 1 00000040 00000000 1 00000001
O 4 00000010 00000001 2 00000000
O 0 0000020c 00000000 2 004182b3
O 5 0000000c 00000000 2 00000001
O 4 00000014 00000002 2 00000000
O 0 00000210 00000000 2 04002303
O 1 00000040 00000000 2 00000001
O 4 00000018 00000001 2 00000000
O 0 00000214 00000000 2 00000013
O 3 00000000 00000000 2 00000000
O 0 00000218 00000000 2 00000013
Q 00000200 00100193 0 1 03 00000001 0 0 0 00000000 0 00000000 00000000
Q 00000204 04302023 0 0 00 00000000 1 1 0 00000040 2 00000001 00000000
Q 00000208 04001203 0 1 04 00000001 1 0 1 00000040 1 00000000 00000001
Q 0000020c 004182b3 0 1 05 00000002 0 0 0 00000000 0 00000000 00000000
C 6 2 1 4

// ==== build.f ====
trace_pkg.sv
trace_assembler.sv
trace_fifo.sv
trace_stats.sv
trace_monitor.sv
trace_monitor_tb.sv
